// File: execPipe_cfg.svh
`ifndef EXEC_PIPE_CFG_SVH
`define EXEC_PIPE_CFG_SVH

// widths fixed by RV32I
`define EXEC_XLEN  32
`define EXEC_REG_W 5

// major opcodes accepted by the pipeline
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_BRANCH 7'b1100011

// funct3 for OP / OP_IMM
`define F3_ADD 3'b000
`define F3_SLL 3'b001
`define F3_XOR 3'b100
`define F3_SRL 3'b101
`define F3_OR  3'b110
`define F3_AND 3'b111

// funct3 for branches
`define F3_BEQ 3'b000
`define F3_BNE 3'b001
`define F3_BLT 3'b100
`define F3_BGE 3'b101

// funct7 marking SUB
`define F7_ALT 7'b0100000

`endif

// File: execPipe_pkg.sv
`include "execPipe_cfg.svh"

package execPipe_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data path widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // operands, results, pc and branch target
    typedef logic [`EXEC_XLEN-1:0] word_t;

    // register index
    typedef logic [`EXEC_REG_W-1:0] regAddr_t;

    // funct3 field, also carries the branch condition
    typedef logic [2:0] funct3_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ALU operations
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL
    } aluOp_e;

endpackage

// File: instrDecode.sv
`timescale 1ns/1ps
`include "execPipe_cfg.svh"

module instrDecode import execPipe_pkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     inStrobe,
    input  word_t    instr,
    input  word_t    rs1Val,
    input  word_t    rs2Val,
    input  word_t    pc,
    output logic     decStrobe,
    output aluOp_e   decOp,
    output word_t    decOpA,
    output word_t    decOpB,
    output logic     decIsBranch,
    output funct3_t  decFunct3,
    output regAddr_t decRdAddr,
    output logic     decRdWrite,
    output word_t    decTarget,
    output logic     decIllegal
);

    // instruction fields
    logic [6:0] opcode;
    logic [6:0] funct7;
    funct3_t    funct3;
    regAddr_t   rdField;
    word_t      immI;
    word_t      immB;
    word_t      shamt;

    // funct3 mapping shared by OP and OP_IMM
    aluOp_e     baseOp;
    logic       baseOk;
    logic       isShift;

    // decoded, before the stage register
    aluOp_e     op;
    word_t      opB;
    logic       isBranch;
    logic       wantsRd;
    logic       illegalNow;

    assign opcode  = instr[6:0];
    assign rdField = instr[11:7];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];

    assign immI  = {{20{instr[31]}}, instr[31:20]};
    assign immB  = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign shamt = {{(`EXEC_XLEN-5){1'b0}}, instr[24:20]};

    assign isShift = (funct3 == `F3_SLL) || (funct3 == `F3_SRL);

    always_comb begin
        baseOp = ALU_ADD;
        baseOk = 1'b1;
        case (funct3)
            `F3_ADD: baseOp = ALU_ADD;
            `F3_SLL: baseOp = ALU_SLL;
            `F3_XOR: baseOp = ALU_XOR;
            `F3_SRL: baseOp = ALU_SRL;
            `F3_OR:  baseOp = ALU_OR;
            `F3_AND: baseOp = ALU_AND;
            // slt, sltu
            default: baseOk = 1'b0;
        endcase
    end

    always_comb begin
        op         = baseOp;
        opB        = rs2Val;
        isBranch   = 1'b0;
        wantsRd    = 1'b0;
        illegalNow = 1'b0;
        case (opcode)
            `OPC_OP: begin
                wantsRd = 1'b1;
                if (funct7 == `F7_ALT && funct3 == `F3_ADD) begin
                    op = ALU_SUB;
                end else if (funct7 != 7'b0 || !baseOk) begin
                    illegalNow = 1'b1;
                end
            end
            `OPC_OP_IMM: begin
                wantsRd = 1'b1;
                opB     = isShift ? shamt : immI;
                // srai and friends carry a nonzero funct7
                if (!baseOk || (isShift && funct7 != 7'b0)) begin
                    illegalNow = 1'b1;
                end
            end
            `OPC_BRANCH: begin
                op       = ALU_SUB;
                isBranch = 1'b1;
                case (funct3)
                    `F3_BEQ, `F3_BNE, `F3_BLT, `F3_BGE: illegalNow = 1'b0;
                    default: illegalNow = 1'b1;
                endcase
            end
            default: illegalNow = 1'b1;
        endcase
        if (illegalNow) begin
            isBranch = 1'b0;
            wantsRd  = 1'b0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decStrobe   <= 1'b0;
            decRdWrite  <= 1'b0;
            decIsBranch <= 1'b0;
            decIllegal  <= 1'b0;
        end else begin
            decStrobe <= inStrobe;
            if (inStrobe) begin
                decRdWrite  <= wantsRd && (rdField != '0);
                decIsBranch <= isBranch;
                decIllegal  <= illegalNow;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inStrobe) begin
            decOp     <= op;
            decOpA    <= rs1Val;
            decOpB    <= opB;
            decFunct3 <= funct3;
            decRdAddr <= rdField;
            decTarget <= pc + immB;
        end
    end

endmodule

// File: aluStage.sv
`timescale 1ns/1ps
`include "execPipe_cfg.svh"

module aluStage import execPipe_pkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     decStrobe,
    input  aluOp_e   decOp,
    input  word_t    decOpA,
    input  word_t    decOpB,
    input  logic     decIsBranch,
    input  funct3_t  decFunct3,
    input  regAddr_t decRdAddr,
    input  logic     decRdWrite,
    input  word_t    decTarget,
    input  logic     decIllegal,
    output logic     outStrobe,
    output regAddr_t rdAddr,
    output logic     rdWrite,
    output word_t    rdData,
    output logic     branchTaken,
    output word_t    branchTarget,
    output logic     illegal
);

    word_t      diff;
    word_t      aluResult;
    logic [4:0] shiftAmt;
    logic       condHolds;

    assign diff     = decOpA - decOpB;
    assign shiftAmt = decOpB[4:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // arithmetic / logic
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (decOp)
            ALU_ADD: aluResult = decOpA + decOpB;
            ALU_SUB: aluResult = diff;
            ALU_XOR: aluResult = decOpA ^ decOpB;
            ALU_OR:  aluResult = decOpA | decOpB;
            ALU_AND: aluResult = decOpA & decOpB;
            // only the low five bits of B count
            ALU_SLL: aluResult = decOpA << shiftAmt;
            ALU_SRL: aluResult = decOpA >> shiftAmt;
            default: aluResult = '0;
        endcase
    end

    // branch condition
    always_comb begin
        case (decFunct3)
            `F3_BEQ: condHolds = (diff == '0);
            `F3_BNE: condHolds = (diff != '0);
            `F3_BLT: condHolds = $signed(decOpA) < $signed(decOpB);
            `F3_BGE: condHolds = $signed(decOpA) >= $signed(decOpB);
            default: condHolds = 1'b0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outStrobe   <= 1'b0;
            rdWrite     <= 1'b0;
            branchTaken <= 1'b0;
            illegal     <= 1'b0;
        end else begin
            outStrobe <= decStrobe;
            if (decStrobe) begin
                rdWrite     <= decRdWrite;
                branchTaken <= decIsBranch && condHolds;
                illegal     <= decIllegal;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (decStrobe) begin
            rdAddr       <= decRdAddr;
            branchTarget <= decTarget;
            // no write-back value for branches or illegal words
            rdData       <= (decIsBranch || decIllegal) ? '0 : aluResult;
        end
    end

endmodule

// File: execPipe.sv
`timescale 1ns/1ps

module execPipe import execPipe_pkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     inStrobe,
    input  word_t    instr,
    input  word_t    rs1Val,
    input  word_t    rs2Val,
    input  word_t    pc,
    output logic     outStrobe,
    output regAddr_t rdAddr,
    output logic     rdWrite,
    output word_t    rdData,
    output logic     branchTaken,
    output word_t    branchTarget,
    output logic     illegal
);

    // decode to execute
    logic     decStrobe;
    aluOp_e   decOp;
    word_t    decOpA;
    word_t    decOpB;
    logic     decIsBranch;
    funct3_t  decFunct3;
    regAddr_t decRdAddr;
    logic     decRdWrite;
    word_t    decTarget;
    logic     decIllegal;

    instrDecode decode (
        .clk         (clk),
        .rstN        (rstN),
        .inStrobe    (inStrobe),
        .instr       (instr),
        .rs1Val      (rs1Val),
        .rs2Val      (rs2Val),
        .pc          (pc),
        .decStrobe   (decStrobe),
        .decOp       (decOp),
        .decOpA      (decOpA),
        .decOpB      (decOpB),
        .decIsBranch (decIsBranch),
        .decFunct3   (decFunct3),
        .decRdAddr   (decRdAddr),
        .decRdWrite  (decRdWrite),
        .decTarget   (decTarget),
        .decIllegal  (decIllegal)
    );

    aluStage execute (
        .clk          (clk),
        .rstN         (rstN),
        .decStrobe    (decStrobe),
        .decOp        (decOp),
        .decOpA       (decOpA),
        .decOpB       (decOpB),
        .decIsBranch  (decIsBranch),
        .decFunct3    (decFunct3),
        .decRdAddr    (decRdAddr),
        .decRdWrite   (decRdWrite),
        .decTarget    (decTarget),
        .decIllegal   (decIllegal),
        .outStrobe    (outStrobe),
        .rdAddr       (rdAddr),
        .rdWrite      (rdWrite),
        .rdData       (rdData),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .illegal      (illegal)
    );

endmodule

// File: tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rstN
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset held for five rising edges
    initial begin
        rstN = 1'b0;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

// File: execPipe_assert.sv
`timescale 1ns/1ps

module execPipe_assert (
    input logic clk,
    input logic rstN,
    input logic inStrobe,
    input logic outStrobe,
    input logic rdWrite,
    input logic branchTaken,
    input logic illegal
);

    // result leaves exactly two cycles after the strobe
    strobeLatency: assert property (@(posedge clk) disable iff (!rstN)
        inStrobe |-> ##2 outStrobe)
        else $error("outStrobe missing two cycles after inStrobe");

    noStrayStrobe: assert property (@(posedge clk) disable iff (!rstN)
        outStrobe |-> $past(inStrobe, 2))
        else $error("outStrobe without inStrobe two cycles earlier");

    branchOrWrite: assert property (@(posedge clk) disable iff (!rstN)
        !(branchTaken && rdWrite))
        else $error("branchTaken and rdWrite high together");

    illegalQuiet: assert property (@(posedge clk) disable iff (!rstN)
        illegal |-> !branchTaken && !rdWrite)
        else $error("illegal result with branchTaken or rdWrite set");

    // async reset keeps the output strobe low
    resetQuiet: assert property (@(posedge clk) !rstN |-> !outStrobe)
        else $error("outStrobe high during reset");

endmodule

// File: execPipe_tb.sv
`timescale 1ns/1ps
`include "execPipe_cfg.svh"

module execPipe_tb import execPipe_pkg::*; ();

    localparam int stimCycles = 600;

    logic     clk;
    logic     rstN;
    logic     inStrobe;
    word_t    instr;
    word_t    rs1Val;
    word_t    rs2Val;
    word_t    pc;
    logic     outStrobe;
    regAddr_t rdAddr;
    logic     rdWrite;
    word_t    rdData;
    logic     branchTaken;
    word_t    branchTarget;
    logic     illegal;

    // one predicted result, due is the cycle it must show up in
    typedef struct packed {
        int       due;
        regAddr_t rdAddr;
        logic     rdWrite;
        word_t    rdData;
        logic     branchTaken;
        word_t    branchTarget;
        logic     illegal;
    } result_t;

    result_t expQ[$];
    result_t front;
    result_t pending;
    word_t   lfsrState;
    word_t   nextInstr;
    word_t   nextA;
    word_t   nextB;
    word_t   nextPc;
    int      cycleCount = 0;
    int      errorCount = 0;
    int      checkedCount = 0;

    tbClock clockGen (
        .clk  (clk),
        .rstN (rstN)
    );

    execPipe uut (.*);

    bind execPipe execPipe_assert assertions (
        .clk         (clk),
        .rstN        (rstN),
        .inStrobe    (inStrobe),
        .outStrobe   (outStrobe),
        .rdWrite     (rdWrite),
        .branchTaken (branchTaken),
        .illegal     (illegal)
    );

    // fibonacci lfsr, taps 32 22 2 1
    function automatic word_t randBits(input int n);
        word_t v;
        logic  fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic result_t predictResult(input word_t ins, input word_t a,
                                              input word_t b, input word_t pcVal);
        result_t    r;
        logic [6:0] opc;
        logic [6:0] f7;
        funct3_t    f3;
        word_t      rhs;
        logic       ok;
        opc = ins[6:0];
        f3  = ins[14:12];
        f7  = ins[31:25];
        r   = '0;
        r.rdAddr = ins[11:7];
        r.branchTarget = pcVal + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        if (opc == `OPC_OP || opc == `OPC_OP_IMM) begin
            ok = (f3 != 3'b010) && (f3 != 3'b011);
            if (opc == `OPC_OP) begin
                rhs = b;
                ok  = ok && (f7 == 7'b0 || (f7 == `F7_ALT && f3 == `F3_ADD));
            end else if (f3 == `F3_SLL || f3 == `F3_SRL) begin
                rhs = {27'b0, ins[24:20]};
                ok  = ok && (f7 == 7'b0);
            end else begin
                rhs = {{20{ins[31]}}, ins[31:20]};
            end
            case (f3)
                `F3_ADD: r.rdData = (opc == `OPC_OP && f7 == `F7_ALT) ? a - rhs : a + rhs;
                `F3_SLL: r.rdData = a << rhs[4:0];
                `F3_XOR: r.rdData = a ^ rhs;
                `F3_SRL: r.rdData = a >> rhs[4:0];
                `F3_OR:  r.rdData = a | rhs;
                default: r.rdData = a & rhs;
            endcase
            r.rdWrite = ok && (ins[11:7] != 5'd0);
            r.illegal = !ok;
            if (!ok) begin
                r.rdData = '0;
            end
        end else if (opc == `OPC_BRANCH) begin
            case (f3)
                `F3_BEQ: r.branchTaken = (a == b);
                `F3_BNE: r.branchTaken = (a != b);
                // signs differ, so the negative one is smaller
                `F3_BLT: r.branchTaken = (a[31] != b[31]) ? a[31] : (a < b);
                `F3_BGE: r.branchTaken = (a[31] != b[31]) ? b[31] : (a >= b);
                default: r.illegal = 1'b1;
            endcase
        end else begin
            r.illegal = 1'b1;
        end
        return r;
    endfunction

    task automatic makeInstruction(output word_t ins, output word_t a, output word_t b);
        word_t       pick;
        funct3_t     f3;
        regAddr_t    rd;
        logic [9:0]  regs;
        logic [11:0] imm;
        logic [1:0]  corner;
        pick   = randBits(5);
        rd     = (randBits(3) == 0) ? 5'd0 : 5'(randBits(5));
        regs   = 10'(randBits(10));
        imm    = 12'(randBits(12));
        f3     = 3'(randBits(3));
        corner = 2'(randBits(2));
        a      = randBits(32);
        b      = randBits(32);
        case (pick[2:0])
            3'd0, 3'd1: begin
                if (f3 == 3'b010 || f3 == 3'b011) f3 = `F3_ADD;
                ins = {(f3 == `F3_ADD && pick[3]) ? `F7_ALT : 7'b0, regs, f3, rd, `OPC_OP};
            end
            3'd2, 3'd3: begin
                if (f3 == 3'b010 || f3 == 3'b011) f3 = `F3_XOR;
                if (f3 == `F3_SLL || f3 == `F3_SRL) imm[11:5] = 7'b0;
                ins = {imm, regs[4:0], f3, rd, `OPC_OP_IMM};
            end
            3'd4, 3'd5: begin
                f3  = {pick[3], 1'b0, pick[4]};
                ins = {imm[11], imm[9:4], regs, f3, imm[3:0], imm[10], `OPC_BRANCH};
                // equal operands and signed overflow pairs
                case (corner)
                    2'd0: b = a;
                    2'd1: begin
                        a = 32'h8000_0000;
                        b = 32'(randBits(8));
                    end
                    2'd2: begin
                        a = 32'h7fff_ffff;
                        b = 32'h8000_0000;
                    end
                    default: ;
                endcase
            end
            3'd6: begin
                // bad funct7 or funct3 on an accepted opcode
                case (pick[4:3])
                    2'd0: ins = {7'b0000001, regs, f3, rd, `OPC_OP};
                    2'd1: ins = {`F7_ALT, regs, `F3_SRL, rd, imm[0] ? `OPC_OP : `OPC_OP_IMM};
                    2'd2: ins = {imm, regs[4:0], 2'b01, imm[1], rd, `OPC_OP_IMM};
                    default: ins = {imm[11:5], regs, 2'b11, imm[0], imm[4:0], `OPC_BRANCH};
                endcase
            end
            default: ins = randBits(32);
        endcase
    endtask

    task automatic reportMismatch(input string what, input word_t got, input word_t want);
        errorCount++;
        $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, want);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // comparator, oldest prediction first
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (outStrobe) begin
            if (expQ.size() == 0) begin
                errorCount++;
                $display("error at %0t ns: output strobe with no instruction in flight", $time);
            end else begin
                front = expQ.pop_front();
                checkedCount++;
                if (cycleCount != front.due)
                    reportMismatch("result cycle", 32'(cycleCount), 32'(front.due));
                if (rdAddr !== front.rdAddr)
                    reportMismatch("rdAddr", 32'(rdAddr), 32'(front.rdAddr));
                if (rdWrite !== front.rdWrite)
                    reportMismatch("rdWrite", 32'(rdWrite), 32'(front.rdWrite));
                if (rdData !== front.rdData)
                    reportMismatch("rdData", rdData, front.rdData);
                if (branchTaken !== front.branchTaken)
                    reportMismatch("branchTaken", 32'(branchTaken), 32'(front.branchTaken));
                if (branchTarget !== front.branchTarget)
                    reportMismatch("branchTarget", branchTarget, front.branchTarget);
                if (illegal !== front.illegal)
                    reportMismatch("illegal", 32'(illegal), 32'(front.illegal));
            end
        end
    end

    initial begin
        inStrobe  = 1'b0;
        instr     = '0;
        rs1Val    = '0;
        rs2Val    = '0;
        pc        = '0;
        lfsrState = 32'hd475;
        @(posedge rstN);
        // quiet after reset, nothing may come out yet
        repeat (3) @(posedge clk);
        for (int slot = 0; slot < stimCycles; slot++) begin
            @(posedge clk);
            // first half back to back, then random gaps
            if (slot < stimCycles / 2 || randBits(2) != 0) begin
                makeInstruction(nextInstr, nextA, nextB);
                nextPc = randBits(32) & 32'hffff_fffc;
                inStrobe <= 1'b1;
                instr    <= nextInstr;
                rs1Val   <= nextA;
                rs2Val   <= nextB;
                pc       <= nextPc;
                pending = predictResult(nextInstr, nextA, nextB, nextPc);
                pending.due = cycleCount + 3;
                expQ.push_back(pending);
            end else begin
                inStrobe <= 1'b0;
            end
        end
        @(posedge clk);
        inStrobe <= 1'b0;
        repeat (4) @(posedge clk);
        if (expQ.size() != 0) begin
            errorCount++;
            $display("error: %0d results never came out of the pipeline", expQ.size());
        end
        $display("%0d results checked, %0d errors", checkedCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // one cycle per stimulus slot plus reset, quiet cycles and drain
    initial begin
        #((stimCycles + 20) * 100);
        $display("timeout: run did not finish within %0d cycles", stimCycles + 20);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: execPipe.f
+incdir+.
execPipe_pkg.sv
instrDecode.sv
aluStage.sv
execPipe.sv
tbClock.sv
execPipe_assert.sv
execPipe_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f execPipe.f --top-module execPipe_tb -o simExec

./obj_dir/simExec | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
    echo "execPipe run passed"
else
    echo "execPipe run failed, see sim.log"
    exit 1
fi
